//--- verilog/usb_line_pkg.sv
/*
 * USB line-level definitions for the soft host PHY.
 * Line state and per-port mask types, bit timing at both speeds,
 * bit stuffing limit, SYNC pattern and EOP length.
 */
package usb_line_pkg;

	// Synchronized {vp, vm} of one port.
	// 0 is SE0, 2 is J at full speed and K at low speed.
	typedef logic [1:0] line_state_t;

	// One bit per port. Bit 0 is port A, bit 1 is port B.
	typedef logic [1:0] port_mask_t;

	localparam line_state_t LINE_SE0 = 2'b00; // Both lines low.

	// The clock is 48 MHz, so 12 Mbit/s takes 4 clocks per bit.
	localparam int FS_BIT_CLKS = 4;
	localparam int LS_BIT_CLKS = 32; // 1.5 Mbit/s.

	// After this many consecutive ones a zero is inserted on the wire.
	localparam int STUFF_LIMIT = 6;

	// SYNC goes out LSB first, seven zeros and then a one (KJKJKJKK).
	localparam logic [7:0] SYNC_BYTE = 8'h80;

	localparam int EOP_SE0_BITS = 2; // SE0 bit times before the closing J.

endpackage

//--- verilog/sie_reg_pkg.sv
/*
 * Register interface of the serial interface engine.
 * I/O address and data types, and the register address map
 * seen by the processor.
 */
package sie_reg_pkg;

	typedef logic [5:0] io_addr_t; // Register address on the I/O strobes.
	typedef logic [7:0] io_data_t; // Register data, also one TX or RX byte.

	// Line states of both ports, read only.
	localparam io_addr_t REG_LINE_A = 6'h00;
	localparam io_addr_t REG_LINE_B = 6'h01;
	// Addresses 0x02 and 0x03 are not used.

	localparam io_addr_t REG_SEL_RX = 6'h04;     // Port the receiver listens to.
	localparam io_addr_t REG_SEL_TX = 6'h05;     // Mask of ports driven on TX.

	// Transmit side.
	localparam io_addr_t REG_TX_DATA    = 6'h06; // Write starts or continues a packet.
	localparam io_addr_t REG_TX_PENDING = 6'h07;
	localparam io_addr_t REG_TX_VALID   = 6'h08; // A write here ends the packet.
	localparam io_addr_t REG_TX_BUSY    = 6'h09;
	localparam io_addr_t REG_GEN_RESET  = 6'h0a; // Per-port SE0 drive.

	// Receive side.
	localparam io_addr_t REG_RX_DATA    = 6'h0b; // Reading clears the pending flag.
	localparam io_addr_t REG_RX_PENDING = 6'h0c;
	localparam io_addr_t REG_RX_ACTIVE  = 6'h0d;

	localparam io_addr_t REG_TX_LS      = 6'h0e; // Low-speed bit time for TX.
	localparam io_addr_t REG_LOW_SPEED  = 6'h0f; // Per-port low-speed mask.
	localparam io_addr_t REG_GEN_EOP    = 6'h10; // Write only strobe.

endpackage

//--- verilog/softusb_sie.sv
/*
 * Register block of the serial interface engine.
 * Write decode into the control registers, TX holding flags,
 * capture of received bytes and the registered read-back mux.
 */
`timescale 1ns/1ps

module softusb_sie
	import usb_line_pkg::*;
	import sie_reg_pkg::*;
(
	input  logic        usb_clk,
	input  logic        usb_rst,

	input  logic        io_re,
	input  logic        io_we,
	input  io_addr_t    io_a,
	input  io_data_t    io_di,
	output io_data_t    io_do,

	input  line_state_t line_state_a,
	input  line_state_t line_state_b,

	output logic        port_sel_rx,
	output port_mask_t  port_sel_tx,
	output port_mask_t  generate_reset,
	output port_mask_t  low_speed,

	output io_data_t    tx_data,
	output logic        tx_valid,
	output logic        tx_low_speed,
	output logic        generate_eop,
	input  logic        tx_ready,
	input  logic        tx_busy,

	input  io_data_t    rx_data,
	input  logic        rx_valid,
	input  logic        rx_active
);

	logic     tx_pending; // Byte written but not yet taken by the TX.
	io_data_t rx_byte;    // Last byte delivered by the receiver.
	logic     rx_pending; // Set by a new byte, cleared by reading it.

	// The EOP request has no storage and goes straight to the PHY.
	assign generate_eop = io_we && (io_a == REG_GEN_EOP);

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			port_sel_rx    <= 1'b0;
			port_sel_tx    <= '0;
			generate_reset <= '0;
			low_speed      <= '0;
			tx_low_speed   <= 1'b0;
			tx_data        <= '0;
			tx_valid       <= 1'b0;
			tx_pending     <= 1'b0;
			rx_byte        <= '0;
			rx_pending     <= 1'b0;
			io_do          <= '0;
		end else begin
			if (tx_ready)
				tx_pending <= 1'b0; // The PHY has latched the byte.

			// A write on the same edge as tx_ready wins, so a fresh byte stays pending.
			if (io_we) begin
				case (io_a)
					REG_SEL_RX:    port_sel_rx    <= io_di[0];
					REG_SEL_TX:    port_sel_tx    <= io_di[1:0];
					REG_TX_DATA: begin
						tx_data    <= io_di; // Overwrites a byte that is still pending.
						tx_valid   <= 1'b1;
						tx_pending <= 1'b1;
					end
					REG_TX_VALID:  tx_valid       <= 1'b0; // EOP follows the current byte.
					REG_GEN_RESET: generate_reset <= io_di[1:0];
					REG_TX_LS:     tx_low_speed   <= io_di[0];
					REG_LOW_SPEED: low_speed      <= io_di[1:0];
					default: ;
				endcase
			end

			if (io_re && (io_a == REG_RX_DATA))
				rx_pending <= 1'b0;
			// A byte arriving during the read must not be lost, so it goes last.
			if (rx_valid) begin
				rx_byte    <= rx_data;
				rx_pending <= 1'b1;
			end

			// Read-back mux, one clock behind the address.
			case (io_a)
				REG_LINE_A:     io_do <= {6'd0, line_state_a};
				REG_LINE_B:     io_do <= {6'd0, line_state_b};
				REG_SEL_RX:     io_do <= {7'd0, port_sel_rx};
				REG_SEL_TX:     io_do <= {6'd0, port_sel_tx};
				REG_TX_DATA:    io_do <= tx_data;
				REG_TX_PENDING: io_do <= {7'd0, tx_pending};
				REG_TX_VALID:   io_do <= {7'd0, tx_valid};
				REG_TX_BUSY:    io_do <= {7'd0, tx_busy};
				REG_GEN_RESET:  io_do <= {6'd0, generate_reset};
				REG_RX_DATA:    io_do <= rx_byte;
				REG_RX_PENDING: io_do <= {7'd0, rx_pending};
				REG_RX_ACTIVE:  io_do <= {7'd0, rx_active};
				REG_TX_LS:      io_do <= {7'd0, tx_low_speed};
				REG_LOW_SPEED:  io_do <= {6'd0, low_speed};
				default:        io_do <= '0; // Unmapped and write-only addresses.
			endcase
		end
	end

endmodule

//--- verilog/softusb_tx.sv
/*
 * USB transmitter.
 * Sends SYNC, then bytes LSB first with bit stuffing and NRZI,
 * then the EOP. Also sends a standalone EOP on request.
 */
`timescale 1ns/1ps

module softusb_tx
	import usb_line_pkg::*;
	import sie_reg_pkg::*;
(
	input  logic     usb_clk,
	input  logic     usb_rst,

	input  io_data_t tx_data,
	input  logic     tx_valid,
	input  logic     tx_low_speed,
	input  logic     generate_eop,

	output logic     tx_ready,
	output logic     tx_busy,
	output logic     tx_dp,
	output logic     tx_dm,
	output logic     tx_oe
);

	localparam int CNT_W   = $clog2(LS_BIT_CLKS);
	localparam int STUFF_W = $clog2(STUFF_LIMIT + 1);
	localparam int EOP_W   = $clog2(EOP_SE0_BITS + 1);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_SYNC,
		TX_DATA,
		TX_EOP_SE0,
		TX_EOP_J
	} tx_state_t;

	tx_state_t          state;
	logic [CNT_W-1:0]   bit_cnt;   // Counts down the clocks of one bit time.
	logic [CNT_W-1:0]   bit_max;
	logic               bit_tick;  // A new bit starts on this edge.
	io_data_t           shreg;     // Byte on the wire, LSB goes first.
	io_data_t           hold;      // First byte of the packet, taken at SYNC start.
	logic [2:0]         bit_idx;
	logic [STUFF_W-1:0] ones;      // Run of ones sent so far.
	logic [EOP_W-1:0]   eop_cnt;
	logic               lvl;       // Line level in J/K terms, 1 is J.
	logic               last_byte; // No further byte, EOP after stuffing.
	logic               stuff_now;
	logic               line_dp;   // Data level on D+ before SE0 forcing.

	assign bit_max   = tx_low_speed ? CNT_W'(LS_BIT_CLKS - 1) : CNT_W'(FS_BIT_CLKS - 1);
	assign bit_tick  = (bit_cnt == '0);
	assign stuff_now = (ones == STUFF_W'(STUFF_LIMIT));

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state     <= TX_IDLE;
			bit_cnt   <= '0;
			bit_idx   <= '0;
			ones      <= '0;
			eop_cnt   <= '0;
			lvl       <= 1'b1;
			last_byte <= 1'b0;
			tx_ready  <= 1'b0;
		end else begin
			tx_ready <= 1'b0;
			bit_cnt  <= bit_tick ? bit_max : bit_cnt - 1'b1;
			case (state)
				TX_IDLE: begin
					lvl       <= 1'b1;
					ones      <= '0;
					bit_idx   <= '0;
					eop_cnt   <= '0;
					last_byte <= 1'b0;
					if (tx_valid) begin
						state    <= TX_SYNC;
						shreg    <= SYNC_BYTE;
						hold     <= tx_data;
						tx_ready <= 1'b1;
						bit_cnt  <= '0; // First SYNC bit goes out on the next edge.
					end else if (generate_eop) begin
						state   <= TX_EOP_SE0;
						bit_cnt <= bit_max; // Full bit time of SE0 from here.
					end
				end
				TX_SYNC, TX_DATA: if (bit_tick) begin
					if (stuff_now) begin
						lvl  <= ~lvl; // Stuffed zero, nothing consumed.
						ones <= '0;
					end else if (last_byte) begin
						state <= TX_EOP_SE0;
					end else begin
						lvl     <= shreg[0] ? lvl : ~lvl; // NRZI, a zero toggles.
						ones    <= shreg[0] ? ones + 1'b1 : '0;
						shreg   <= shreg >> 1;
						bit_idx <= bit_idx + 3'd1;
						// Last bit of a byte is on the wire now, so line up the next one.
						if (bit_idx == 3'd7) begin
							if (state == TX_SYNC) begin
								shreg <= hold;
								state <= TX_DATA;
							end else if (tx_valid) begin
								shreg    <= tx_data;
								tx_ready <= 1'b1;
							end else begin
								last_byte <= 1'b1;
							end
						end
					end
				end
				TX_EOP_SE0: if (bit_tick) begin
					if (eop_cnt == EOP_W'(EOP_SE0_BITS - 1)) begin
						state <= TX_EOP_J;
						lvl   <= 1'b1;
					end else begin
						eop_cnt <= eop_cnt + 1'b1;
					end
				end
				TX_EOP_J: if (bit_tick)
					state <= TX_IDLE; // One J bit time closes the EOP.
				default: state <= TX_IDLE;
			endcase
		end
	end

	assign tx_busy = (state != TX_IDLE);
	assign tx_oe   = tx_busy;

	// J is D+ high at full speed and D- high at low speed.
	assign line_dp = lvl ^ tx_low_speed;
	assign tx_dp   = (state != TX_EOP_SE0) & line_dp;
	assign tx_dm   = (state != TX_EOP_SE0) & ~line_dp;

endmodule

//--- verilog/softusb_rx.sv
/*
 * USB receiver.
 * Oversamples the selected port, recovers bit timing from edges,
 * hunts for SYNC, decodes NRZI, drops stuffed bits and assembles
 * bytes until an SE0 ends the packet.
 */
`timescale 1ns/1ps

module softusb_rx
	import usb_line_pkg::*;
	import sie_reg_pkg::*;
(
	input  logic        usb_clk,
	input  logic        usb_rst,

	input  logic        rx_rcv,
	input  line_state_t rx_line,
	input  logic        rx_low_speed,

	output io_data_t    rx_data,
	output logic        rx_valid,
	output logic        rx_active
);

	localparam int CNT_W          = $clog2(LS_BIT_CLKS);
	localparam int STUFF_W        = $clog2(STUFF_LIMIT + 1);
	localparam int SYNC_MIN_ZEROS = 3; // Fewer zeros before the closing one is noise.

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_SYNC_HUNT,
		RX_DATA
	} rx_state_t;

	rx_state_t          state;
	logic               rcv_meta;
	logic               rcv_sync;
	logic               rcv_prev;
	logic               edge_seen;
	logic [CNT_W-1:0]   bit_cnt;
	logic [CNT_W-1:0]   bit_max;
	logic [CNT_W-1:0]   bit_mid;
	logic               sample;  // Middle of a bit time.
	logic               lvl_j;   // Received level in J/K terms, 1 is J.
	logic               prev_j;
	logic               dec_bit; // NRZI decoded bit.
	logic               se0;
	io_data_t           shreg;
	logic [2:0]         bit_idx;
	logic [STUFF_W-1:0] ones;
	logic [2:0]         zeros;   // SYNC zeros seen while hunting.

	// Two flops match the line state synchronizers in the PHY.
	always_ff @(posedge usb_clk) begin
		rcv_meta <= rx_rcv;
		rcv_sync <= rcv_meta;
		rcv_prev <= rcv_sync;
	end

	assign edge_seen = rcv_sync ^ rcv_prev;
	assign bit_max   = rx_low_speed ? CNT_W'(LS_BIT_CLKS - 1) : CNT_W'(FS_BIT_CLKS - 1);
	assign bit_mid   = rx_low_speed ? CNT_W'(LS_BIT_CLKS / 2) : CNT_W'(FS_BIT_CLKS / 2);
	assign sample    = (bit_cnt == bit_mid) && !edge_seen;
	assign lvl_j     = rcv_sync ^ rx_low_speed; // Polarity of J swaps at low speed.
	assign dec_bit   = (lvl_j == prev_j);       // No change on the line is a one.
	assign se0       = (rx_line == LINE_SE0);

	// Bit timer, pulled back to the start of the bit on every edge.
	always_ff @(posedge usb_clk) begin
		if (usb_rst)
			bit_cnt <= '0;
		else if (edge_seen)
			bit_cnt <= CNT_W'(1); // The edge clock itself was the first of the bit.
		else if (bit_cnt == bit_max)
			bit_cnt <= '0;
		else
			bit_cnt <= bit_cnt + 1'b1;
	end

	always_ff @(posedge usb_clk) begin
		if (usb_rst) begin
			state     <= RX_IDLE;
			rx_active <= 1'b0;
			rx_valid  <= 1'b0;
			prev_j    <= 1'b1;
			bit_idx   <= '0;
			ones      <= '0;
			zeros     <= '0;
		end else begin
			rx_valid <= 1'b0;
			if (se0) begin
				state     <= RX_IDLE; // EOP or bus reset, a partial byte is dropped.
				rx_active <= 1'b0;
				prev_j    <= 1'b1;    // The bus returns to J after SE0.
			end else if (sample) begin
				prev_j <= lvl_j;
				case (state)
					RX_IDLE: if (!dec_bit) begin
						state <= RX_SYNC_HUNT; // First K of a possible SYNC.
						zeros <= '0;
					end
					RX_SYNC_HUNT: begin
						if (!dec_bit) begin
							if (zeros != 3'd7)
								zeros <= zeros + 3'd1;
						end else if (zeros >= 3'(SYNC_MIN_ZEROS)) begin
							state     <= RX_DATA; // The closing one of SYNC.
							rx_active <= 1'b1;
							ones      <= STUFF_W'(1); // It counts toward stuffing.
							bit_idx   <= '0;
						end else begin
							state <= RX_IDLE;
						end
					end
					RX_DATA: begin
						if (ones == STUFF_W'(STUFF_LIMIT)) begin
							ones <= '0; // Stuffed zero, not data.
						end else begin
							ones    <= dec_bit ? ones + 1'b1 : '0;
							shreg   <= {dec_bit, shreg[7:1]};
							bit_idx <= bit_idx + 3'd1;
							if (bit_idx == 3'd7) begin
								rx_data  <= {dec_bit, shreg[7:1]};
								rx_valid <= 1'b1;
							end
						end
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

endmodule

//--- verilog/softusb_phy.sv
/*
 * Two-port USB PHY.
 * Line state synchronizers, receive port and speed selection,
 * per-port drive with bus reset priority, and the TX and RX.
 */
`timescale 1ns/1ps

module softusb_phy
	import usb_line_pkg::*;
	import sie_reg_pkg::*;
(
	input  logic        usb_clk,
	input  logic        usb_rst,

	output logic        usba_spd,
	output logic        usba_oe_n,
	output logic        usba_txp,
	output logic        usba_txm,
	input  logic        usba_rcv,
	input  logic        usba_vp,
	input  logic        usba_vm,

	output logic        usbb_spd,
	output logic        usbb_oe_n,
	output logic        usbb_txp,
	output logic        usbb_txm,
	input  logic        usbb_rcv,
	input  logic        usbb_vp,
	input  logic        usbb_vm,

	output line_state_t line_state_a,
	output line_state_t line_state_b,

	input  logic        port_sel_rx,
	input  port_mask_t  port_sel_tx,
	input  port_mask_t  generate_reset,
	input  port_mask_t  low_speed,

	input  io_data_t    tx_data,
	input  logic        tx_valid,
	input  logic        tx_low_speed,
	input  logic        generate_eop,
	output logic        tx_ready,
	output logic        tx_busy,

	output io_data_t    rx_data,
	output logic        rx_valid,
	output logic        rx_active
);

	port_mask_t  vp_pin;
	port_mask_t  vm_pin;
	port_mask_t  rcv_pin;
	port_mask_t  txp_pin;
	port_mask_t  txm_pin;
	port_mask_t  oe_n_pin;
	line_state_t line_meta [2];
	line_state_t line_sync [2];
	logic        tx_dp;
	logic        tx_dm;
	logic        tx_oe;
	logic        rx_rcv;
	line_state_t rx_line;
	logic        rx_low_speed;

	// Both ports are handled as bit 0 (A) and bit 1 (B) of one vector.
	assign vp_pin  = {usbb_vp, usba_vp};
	assign vm_pin  = {usbb_vm, usba_vm};
	assign rcv_pin = {usbb_rcv, usba_rcv};

	always_ff @(posedge usb_clk) begin
		for (int i = 0; i < 2; i++) begin
			line_meta[i] <= {vp_pin[i], vm_pin[i]};
			line_sync[i] <= line_meta[i];
		end
	end

	assign line_state_a = line_sync[0];
	assign line_state_b = line_sync[1];

	// Bus reset overrides any transmission on its port.
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			txp_pin[i]  = tx_dp;
			txm_pin[i]  = tx_dm;
			oe_n_pin[i] = 1'b1;
			if (generate_reset[i]) begin
				txp_pin[i]  = 1'b0; // SE0 for as long as the bit stays set.
				txm_pin[i]  = 1'b0;
				oe_n_pin[i] = 1'b0;
			end else if (port_sel_tx[i] && tx_oe) begin
				oe_n_pin[i] = 1'b0;
			end
		end
	end

	assign usba_txp  = txp_pin[0];
	assign usba_txm  = txm_pin[0];
	assign usba_oe_n = oe_n_pin[0];
	assign usbb_txp  = txp_pin[1];
	assign usbb_txm  = txm_pin[1];
	assign usbb_oe_n = oe_n_pin[1];
	assign usba_spd  = ~low_speed[0]; // Transceiver speed pin is high for full speed.
	assign usbb_spd  = ~low_speed[1];

	// The receiver sees only the selected port.
	assign rx_rcv       = rcv_pin[port_sel_rx];
	assign rx_line      = line_sync[port_sel_rx];
	assign rx_low_speed = low_speed[port_sel_rx];

	softusb_tx tx (.*);
	softusb_rx rx (.*);

endmodule

//--- verilog/softusb_top.sv
/*
 * Top level of the soft USB serial interface engine.
 * Register block and two-port PHY.
 */
`timescale 1ns/1ps

module softusb_top
	import usb_line_pkg::*;
	import sie_reg_pkg::*;
(
	input  logic     usb_clk,
	input  logic     usb_rst,

	input  logic     io_re,
	input  logic     io_we,
	input  io_addr_t io_a,
	input  io_data_t io_di,
	output io_data_t io_do,

	output logic     usba_spd,
	output logic     usba_oe_n,
	output logic     usba_txp,
	output logic     usba_txm,
	input  logic     usba_rcv,
	input  logic     usba_vp,
	input  logic     usba_vm,

	output logic     usbb_spd,
	output logic     usbb_oe_n,
	output logic     usbb_txp,
	output logic     usbb_txm,
	input  logic     usbb_rcv,
	input  logic     usbb_vp,
	input  logic     usbb_vm
);

	line_state_t line_state_a;
	line_state_t line_state_b;
	logic        port_sel_rx;
	port_mask_t  port_sel_tx;
	port_mask_t  generate_reset;
	port_mask_t  low_speed;
	io_data_t    tx_data;
	logic        tx_valid;
	logic        tx_low_speed;
	logic        generate_eop;
	logic        tx_ready;
	logic        tx_busy;
	io_data_t    rx_data;
	logic        rx_valid;
	logic        rx_active;

	// Signal names match on both sides, so the instances connect by name.
	softusb_sie sie (.*);
	softusb_phy phy (.*);

endmodule

//--- tb/tb_softusb.sv
/*
 * Testbench for the soft USB serial interface engine.
 * Port A transmits into port B through a registered loopback.
 * Covers reset values, control registers, packets at both speeds,
 * bit stuffing, a standalone EOP and a bus reset.
 */
`timescale 1ns/1ps

module tb_softusb
	import usb_line_pkg::*;
	import sie_reg_pkg::*;
();

	localparam line_state_t FS_J     = 2'b10; // J at full speed, D+ high.
	localparam int          NUM_PKTS = 8;
	localparam int          NUM_REGS = 15;
	localparam int          FS_POLLS = 400;  // Poll limit of one wait at full speed.
	localparam int          LS_POLLS = 3200; // Low speed bits are eight times longer.

	logic     usb_clk = 1'b0;
	logic     usb_rst;
	logic     io_re;
	logic     io_we;
	io_addr_t io_a;
	io_data_t io_di;
	io_data_t io_do;
	logic     usba_spd;
	logic     usba_oe_n;
	logic     usba_txp;
	logic     usba_txm;
	logic     usba_rcv;
	logic     usba_vp;
	logic     usba_vm;
	logic     usbb_spd;
	logic     usbb_oe_n;
	logic     usbb_txp;
	logic     usbb_txm;
	logic     usbb_rcv = 1'b1; // Port B starts at full-speed idle J.
	logic     usbb_vp  = 1'b1;
	logic     usbb_vm  = 1'b0;
	logic     ls_mode  = 1'b0; // Idle polarity of port B follows its speed.

	int errors     = 0;
	int tests_pass = 0;
	int tests_fail = 0;

	// Control register table, written and read back in order.
	io_addr_t   reg_addr [NUM_REGS];
	io_data_t   reg_wr   [NUM_REGS];
	io_data_t   reg_exp  [NUM_REGS];
	// Packet table. Bit i of pkt_rnd replaces byte i with a random value.
	logic       pkt_ls   [NUM_PKTS];
	int         pkt_len  [NUM_PKTS];
	logic [3:0] pkt_rnd  [NUM_PKTS];
	io_data_t   pkt_data [NUM_PKTS][4];

	always #4 usb_clk = ~usb_clk; // 8 ns period.

	softusb_top i_dut (.*);

	// Port B hears port A while A drives, and an idle J otherwise.
	always @(posedge usb_clk) begin
		if (!usba_oe_n) begin
			usbb_vp  <= usba_txp;
			usbb_vm  <= usba_txm;
			usbb_rcv <= usba_txp; // The differential receiver follows D+.
		end else begin
			usbb_vp  <= ~ls_mode; // J is D- high at low speed.
			usbb_vm  <= ls_mode;
			usbb_rcv <= ~ls_mode;
		end
	end

	task automatic check_data(input string name, input io_data_t exp, input io_data_t got);
		if (got !== exp) begin
			$display("[FAIL] %s exp=%02h got=%02h", name, exp, got);
			errors++;
		end
	endtask

	task automatic check_line(input string name, input line_state_t exp, input line_state_t got);
		if (got !== exp) begin
			$display("[FAIL] %s exp=%01h got=%01h", name, exp, got);
			errors++;
		end
	endtask

	task automatic io_write(input io_addr_t addr, input io_data_t data);
		@(posedge usb_clk);
		io_a  <= addr;
		io_di <= data;
		io_we <= 1'b1;
		@(posedge usb_clk); // The write lands on this edge.
		io_we <= 1'b0;
	endtask

	task automatic io_read(input io_addr_t addr, output io_data_t data);
		@(posedge usb_clk);
		io_a  <= addr;
		io_re <= 1'b1;
		@(posedge usb_clk); // The read mux registers this address here.
		io_re <= 1'b0;
		@(negedge usb_clk);
		data = io_do; // Stable half a clock after the edge.
	endtask

	// Polls a register until it holds the expected value or the limit runs out.
	task automatic wait_reg(input string what, input io_addr_t addr, input io_data_t exp,
			input int limit, output io_data_t val);
		int polls;
		polls = 0;
		io_read(addr, val);
		while ((val !== exp) && (polls < limit)) begin
			io_read(addr, val);
			polls++;
		end
		if (val !== exp) begin
			$display("Timed out after %0d polls waiting for %s, last value %02h.",
				polls, what, val);
			errors++;
		end
	endtask

	task automatic receive_byte(input io_data_t exp, input int limit);
		io_data_t val;
		wait_reg("rx_pending to rise", REG_RX_PENDING, 8'h01, limit, val);
		io_read(REG_RX_DATA, val); // This read also clears rx_pending.
		check_data("rx_data", exp, val);
	endtask

	task automatic finish_test(input string name, input int err_before);
		if (errors == err_before) begin
			tests_pass++;
			$display("ok     %s", name);
		end else begin
			tests_fail++;
			$display("error  %s, %0d errors", name, errors - err_before);
		end
	endtask

	task automatic set_reg_row(input int idx, input io_addr_t addr, input io_data_t wr,
			input io_data_t exp);
		reg_addr[idx] = addr;
		reg_wr[idx]   = wr;
		reg_exp[idx]  = exp;
	endtask

	task automatic set_pkt(input int idx, input logic ls, input int len, input logic [3:0] rnd,
			input io_data_t b0, input io_data_t b1, input io_data_t b2, input io_data_t b3);
		pkt_ls[idx]      = ls;
		pkt_len[idx]     = len;
		pkt_rnd[idx]     = rnd;
		pkt_data[idx][0] = b0;
		pkt_data[idx][1] = b1;
		pkt_data[idx][2] = b2;
		pkt_data[idx][3] = b3;
	endtask

	// TX speed and the low-speed bit of port B, with port B's idle level to match.
	task automatic set_speed(input logic ls);
		@(posedge usb_clk);
		ls_mode <= ls;
		io_write(REG_TX_LS, {7'd0, ls});
		io_write(REG_LOW_SPEED, {6'd0, ls, 1'b0});
		// A polarity switch can look like a lone K, so the receiver gets time to drop it.
		repeat (8 * LS_BIT_CLKS) @(posedge usb_clk);
	endtask

	task automatic send_packet(input int p);
		io_data_t bytes [4];
		io_data_t val;
		int       limit;
		int       len;
		int       err_before;
		err_before = errors;
		limit      = pkt_ls[p] ? LS_POLLS : FS_POLLS;
		len        = pkt_len[p];
		for (int i = 0; i < 4; i++)
			bytes[i] = pkt_rnd[p][i] ? io_data_t'($urandom) : pkt_data[p][i];
		set_speed(pkt_ls[p]);
		if (pkt_ls[p]) begin
			@(negedge usb_clk);
			check_data("usbb_spd", 8'h00, io_data_t'(usbb_spd));
			check_data("usba_spd", 8'h01, io_data_t'(usba_spd));
		end
		// Byte i goes in once byte i-1 is latched, and byte i-2 has just arrived.
		for (int i = 0; i < len; i++) begin
			wait_reg("tx_pending to fall", REG_TX_PENDING, 8'h00, limit, val);
			io_write(REG_TX_DATA, bytes[i]);
			if (i >= 2)
				receive_byte(bytes[i - 2], limit);
		end
		wait_reg("tx_pending to fall", REG_TX_PENDING, 8'h00, limit, val);
		io_write(REG_TX_VALID, 8'h00); // EOP after the last byte.
		if (len >= 2)
			receive_byte(bytes[len - 2], limit);
		receive_byte(bytes[len - 1], limit);
		io_read(REG_RX_PENDING, val);
		check_data("rx_pending", 8'h00, val);
		wait_reg("rx_active to fall", REG_RX_ACTIVE, 8'h00, limit, val);
		wait_reg("tx_busy to fall", REG_TX_BUSY, 8'h00, limit, val);
		finish_test($sformatf("packet %0d, %s speed, %0d bytes", p,
			pkt_ls[p] ? "low" : "full", len), err_before);
	endtask

	initial begin
		io_data_t val;
		int       err_before;
		void'($urandom(14));
		usb_rst  = 1'b1;
		io_re    = 1'b0;
		io_we    = 1'b0;
		io_a     = '0;
		io_di    = '0;
		usba_vp  = 1'b1; // Port A only listens to an idle J.
		usba_vm  = 1'b0;
		usba_rcv = 1'b1;

		set_reg_row(0,  REG_SEL_RX,    8'hff, 8'h01); // Each field is masked to its width.
		set_reg_row(1,  REG_SEL_RX,    8'h00, 8'h00);
		set_reg_row(2,  REG_SEL_TX,    8'hff, 8'h03);
		set_reg_row(3,  REG_SEL_TX,    8'h02, 8'h02);
		set_reg_row(4,  REG_TX_LS,     8'hff, 8'h01);
		set_reg_row(5,  REG_TX_LS,     8'h00, 8'h00);
		set_reg_row(6,  REG_LOW_SPEED, 8'h5a, 8'h02);
		set_reg_row(7,  REG_LOW_SPEED, 8'h00, 8'h00);
		set_reg_row(8,  REG_GEN_RESET, 8'hfe, 8'h02);
		set_reg_row(9,  REG_GEN_RESET, 8'h00, 8'h00);
		set_reg_row(10, REG_SEL_TX,    8'h00, 8'h00);
		set_reg_row(11, 6'h02,         8'hff, 8'h00); // Unmapped from here on.
		set_reg_row(12, 6'h03,         8'hff, 8'h00);
		set_reg_row(13, 6'h11,         8'hff, 8'h00);
		set_reg_row(14, 6'h3f,         8'hff, 8'h00);

		set_pkt(0, 1'b0, 1, 4'b0000, 8'ha5, 8'h00, 8'h00, 8'h00);
		set_pkt(1, 1'b0, 4, 4'b0000, 8'h01, 8'h23, 8'hc3, 8'h5a);
		set_pkt(2, 1'b0, 3, 4'b0111, 8'h00, 8'h00, 8'h00, 8'h00);
		set_pkt(3, 1'b0, 2, 4'b0000, 8'hff, 8'hff, 8'h00, 8'h00); // Stuffing in every byte.
		set_pkt(4, 1'b0, 4, 4'b0000, 8'h7f, 8'hfe, 8'h7f, 8'hfe); // Runs across byte edges.
		set_pkt(5, 1'b0, 4, 4'b1110, 8'h3c, 8'h00, 8'h00, 8'h00);
		set_pkt(6, 1'b1, 3, 4'b0111, 8'h00, 8'h00, 8'h00, 8'h00);
		set_pkt(7, 1'b1, 2, 4'b0010, 8'hff, 8'h00, 8'h00, 8'h00);

		repeat (7) @(posedge usb_clk);
		@(negedge usb_clk);
		err_before = errors;
		check_data("io_do", 8'h00, io_do);
		@(posedge usb_clk);
		usb_rst <= 1'b0; // Released after the eighth reset edge.

		io_read(REG_LINE_A, val);
		check_line("line_state_a", FS_J, val[1:0]);
		io_read(REG_LINE_B, val);
		check_line("line_state_b", FS_J, val[1:0]);
		for (int a = 4; a <= 16; a++) begin
			io_read(io_addr_t'(a), val);
			check_data($sformatf("reg 0x%02h", a), 8'h00, val);
		end
		@(negedge usb_clk);
		check_data("usba_oe_n", 8'h01, io_data_t'(usba_oe_n));
		check_data("usbb_oe_n", 8'h01, io_data_t'(usbb_oe_n));
		check_data("usba_spd", 8'h01, io_data_t'(usba_spd));
		check_data("usbb_spd", 8'h01, io_data_t'(usbb_spd));
		finish_test("reset defaults", err_before);

		err_before = errors;
		for (int r = 0; r < NUM_REGS; r++) begin
			io_write(reg_addr[r], reg_wr[r]);
			io_read(reg_addr[r], val);
			check_data($sformatf("reg 0x%02h", reg_addr[r]), reg_exp[r], val);
		end
		finish_test("control registers", err_before);

		io_write(REG_SEL_TX, 8'h01); // Port A transmits.
		io_write(REG_SEL_RX, 8'h01); // Port B receives.
		for (int p = 0; p < NUM_PKTS; p++)
			send_packet(p);
		set_speed(1'b0);

		err_before = errors;
		io_write(REG_GEN_EOP, 8'h01);
		wait_reg("tx_busy to rise", REG_TX_BUSY, 8'h01, FS_POLLS, val);
		wait_reg("tx_busy to fall", REG_TX_BUSY, 8'h00, FS_POLLS, val);
		io_read(REG_RX_PENDING, val);
		check_data("rx_pending", 8'h00, val); // An EOP alone carries no byte.
		io_read(REG_RX_ACTIVE, val);
		check_data("rx_active", 8'h00, val);
		finish_test("standalone EOP", err_before);

		err_before = errors;
		io_write(REG_GEN_RESET, 8'h01);
		wait_reg("line_state_b to show SE0", REG_LINE_B, 8'h00, FS_POLLS, val);
		check_line("line_state_b", LINE_SE0, val[1:0]);
		@(negedge usb_clk);
		check_data("usba_oe_n", 8'h00, io_data_t'(usba_oe_n));
		check_data("usba_txp", 8'h00, io_data_t'(usba_txp));
		check_data("usba_txm", 8'h00, io_data_t'(usba_txm));
		check_data("usbb_oe_n", 8'h01, io_data_t'(usbb_oe_n));
		io_write(REG_GEN_RESET, 8'h00);
		wait_reg("line_state_b to return to J", REG_LINE_B, io_data_t'(FS_J), FS_POLLS, val);
		check_line("line_state_b", FS_J, val[1:0]);
		@(negedge usb_clk);
		check_data("usba_oe_n", 8'h01, io_data_t'(usba_oe_n));
		// Port B alone in reset drives SE0 on its own pins and leaves port A idle.
		io_write(REG_GEN_RESET, 8'h02);
		@(negedge usb_clk);
		check_data("usbb_oe_n", 8'h00, io_data_t'(usbb_oe_n));
		check_data("usbb_txp", 8'h00, io_data_t'(usbb_txp));
		check_data("usbb_txm", 8'h00, io_data_t'(usbb_txm));
		check_data("usba_oe_n", 8'h01, io_data_t'(usba_oe_n));
		io_write(REG_GEN_RESET, 8'h00);
		@(negedge usb_clk);
		check_data("usbb_oe_n", 8'h01, io_data_t'(usbb_oe_n));
		finish_test("bus reset on each port", err_before);

		$display("%0d tests passed, %0d tests failed, %0d errors", tests_pass, tests_fail,
			errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- compile.f
verilog/usb_line_pkg.sv
verilog/sie_reg_pkg.sv
verilog/softusb_sie.sv
verilog/softusb_tx.sv
verilog/softusb_rx.sv
verilog/softusb_phy.sv
verilog/softusb_top.sv
tb/tb_softusb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_softusb -f compile.f -o tb_softusb \
	&& ./obj_dir/tb_softusb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete."; exit 1; }
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && exit 1 || exit 0
